/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_mini_spart
FILELIST = mini_spart.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* common/spart_bus_if.sv */
`default_nettype none

interface spart_bus_if
	import spart_pkg::*;
();

	// Access strobe and direction, iorw high is a read
	logic    iocs;
	logic    iorw;
	ioaddr_t ioaddr;
	data_t   wdata;

	// Read data and status strobes from the SPART
	data_t   rdata;
	logic    rda;
	logic    tbr;

	modport driver (
		output iocs,
		output iorw,
		output ioaddr,
		output wdata,
		input  rdata,
		input  rda,
		input  tbr
	);

	modport spart (
		input  iocs,
		input  iorw,
		input  ioaddr,
		input  wdata,
		output rdata,
		output rda,
		output tbr
	);

endinterface

`default_nettype wire

/* common/spart_pkg.sv */
`default_nettype none

package spart_pkg;

	////////////////////
	// Bus and data widths
	////////////////////
	typedef logic [7:0]  data_t;
	typedef logic [1:0]  ioaddr_t;
	typedef logic [15:0] divisor_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// Register bus addresses
	localparam ioaddr_t IOADDR_DATA    = 2'd0;
	localparam ioaddr_t IOADDR_STATUS  = 2'd1;
	localparam ioaddr_t IOADDR_DB_LOW  = 2'd2;
	localparam ioaddr_t IOADDR_DB_HIGH = 2'd3;

	// Monitor command and reply characters
	localparam data_t CHAR_ENTER = 8'h0d;
	localparam data_t CHAR_DEC   = 8'h31;
	localparam data_t CHAR_INC   = 8'h32;
	localparam data_t CHAR_SPACE = 8'h20;
	localparam data_t CHAR_ZERO  = 8'h30;

	////////////////////
	// Baud divisors, clocks per 16x sample tick
	////////////////////
	localparam divisor_t BAUD_DIV_4800  = 16'd650;
	localparam divisor_t BAUD_DIV_9600  = 16'd325;
	localparam divisor_t BAUD_DIV_19200 = 16'd162;
	localparam divisor_t BAUD_DIV_38400 = 16'd80;

	// br_cfg selects one of the four rates
	function automatic divisor_t baud_divisor(input logic [1:0] br_cfg);
		case (br_cfg)
			2'b00:   return BAUD_DIV_4800;
			2'b01:   return BAUD_DIV_9600;
			2'b10:   return BAUD_DIV_19200;
			default: return BAUD_DIV_38400;
		endcase
	endfunction

endpackage

`default_nettype wire

/* design/driver.sv */
`default_nettype none

module driver
	import spart_pkg::*;
#(
	parameter int NUM_TRACE = 6
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [1:0]  br_cfg,
	spart_bus_if.driver bus,
	output logic [7:0]  trace_idx,
	input  word_t       trace_val
);

	typedef enum logic [2:0] {
		INIT_LOW_DB,
		INIT_HIGH_DB,
		RECEIVE_WAIT,
		SEND_INDEX,
		SEND_VALUE,
		SEND_SPACE,
		PRINT_PTR
	} state_t;

	localparam logic [7:0] TRACE_END = 8'(NUM_TRACE);

	state_t     state;
	state_t     next_state;
	logic [7:0] ptr;
	logic       ptr_inc;
	logic       ptr_dec;
	divisor_t   divisor;
	data_t      ptr_digit;

	assign divisor   = baud_divisor(br_cfg);
	assign ptr_digit = CHAR_ZERO + {4'b0, ptr[3:0]};
	assign trace_idx = ptr;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= INIT_LOW_DB;
		else
			state <= next_state;
	end

	// Trace pointer wraps modulo 256
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ptr <= '0;
		else if (ptr_inc)
			ptr <= ptr + 8'd1;
		else if (ptr_dec)
			ptr <= ptr - 8'd1;
	end

	////////////////////
	// Monitor FSM
	////////////////////
	always_comb begin
		next_state = state;
		bus.iocs   = 1'b0;
		bus.iorw   = 1'b1;
		bus.ioaddr = IOADDR_DATA;
		bus.wdata  = '0;
		ptr_inc    = 1'b0;
		ptr_dec    = 1'b0;

		case (state)
			INIT_LOW_DB: begin
				bus.iocs   = 1'b1;
				bus.iorw   = 1'b0;
				bus.ioaddr = IOADDR_DB_LOW;
				bus.wdata  = divisor[7:0];
				next_state = INIT_HIGH_DB;
			end
			INIT_HIGH_DB: begin
				bus.iocs   = 1'b1;
				bus.iorw   = 1'b0;
				bus.ioaddr = IOADDR_DB_HIGH;
				bus.wdata  = divisor[15:8];
				next_state = RECEIVE_WAIT;
			end
			RECEIVE_WAIT: begin
				// Read the character and decode it in the same cycle
				if (bus.rda) begin
					bus.iocs = 1'b1;
					case (bus.rdata)
						CHAR_ENTER: next_state = SEND_INDEX;
						CHAR_DEC: begin
							ptr_dec    = 1'b1;
							next_state = PRINT_PTR;
						end
						CHAR_INC: begin
							ptr_inc    = 1'b1;
							next_state = PRINT_PTR;
						end
						default: next_state = RECEIVE_WAIT;
					endcase
				end
			end
			SEND_INDEX: begin
				// Dump ends once the pointer passes the last trace register
				if (ptr >= TRACE_END) begin
					next_state = RECEIVE_WAIT;
				end else if (bus.tbr) begin
					bus.iocs   = 1'b1;
					bus.iorw   = 1'b0;
					bus.wdata  = ptr_digit;
					next_state = SEND_VALUE;
				end
			end
			SEND_VALUE: begin
				if (bus.tbr) begin
					bus.iocs   = 1'b1;
					bus.iorw   = 1'b0;
					bus.wdata  = trace_val[7:0];
					ptr_inc    = 1'b1;
					next_state = SEND_SPACE;
				end
			end
			SEND_SPACE: begin
				if (bus.tbr) begin
					bus.iocs   = 1'b1;
					bus.iorw   = 1'b0;
					bus.wdata  = CHAR_SPACE;
					next_state = SEND_INDEX;
				end
			end
			PRINT_PTR: begin
				// Pointer already holds the new value here
				if (bus.tbr) begin
					bus.iocs   = 1'b1;
					bus.iorw   = 1'b0;
					bus.wdata  = ptr_digit;
					next_state = RECEIVE_WAIT;
				end
			end
			default: next_state = INIT_LOW_DB;
		endcase
	end

endmodule

`default_nettype wire

/* design/mini_spart_top.sv */
`default_nettype none

module mini_spart_top
	import spart_pkg::*;
#(
	parameter int NUM_TRACE = 6
) (
	input  logic       clk,
	input  logic       rst,
	input  logic [1:0] br_cfg,
	input  logic       rxd,
	output logic       txd,
	input  logic       wb_we,
	input  reg_idx_t   wb_reg,
	input  word_t      wb_data
);

	spart_bus_if bus ();

	logic [7:0] trace_idx;
	word_t      trace_val;

	driver #(
		.NUM_TRACE (NUM_TRACE)
	) u_driver (
		.clk       (clk),
		.rst       (rst),
		.br_cfg    (br_cfg),
		.bus       (bus.driver),
		.trace_idx (trace_idx),
		.trace_val (trace_val)
	);

	// Writeback capture from the external processor
	trace_regs #(
		.NUM_TRACE (NUM_TRACE)
	) u_trace_regs (
		.clk       (clk),
		.rst       (rst),
		.wb_we     (wb_we),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data),
		.trace_idx (trace_idx),
		.trace_val (trace_val)
	);

	spart u_spart (
		.clk (clk),
		.rst (rst),
		.bus (bus.spart),
		.rxd (rxd),
		.txd (txd)
	);

endmodule

`default_nettype wire

/* design/trace_regs.sv */
`default_nettype none

module trace_regs
	import spart_pkg::*;
#(
	parameter int NUM_TRACE = 6
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       wb_we,
	input  reg_idx_t   wb_reg,
	input  word_t      wb_data,
	input  logic [7:0] trace_idx,
	output word_t      trace_val
);

	word_t vals [NUM_TRACE];

	// Register numbers at or above NUM_TRACE match no entry
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < NUM_TRACE; i++)
				vals[i] <= '0;
		end else if (wb_we) begin
			for (int i = 0; i < NUM_TRACE; i++)
				if (wb_reg == reg_idx_t'(i))
					vals[i] <= wb_data;
		end
	end

	// Out of range index reads as 0xff
	always_comb begin
		trace_val = 32'h0000_00ff;
		for (int i = 0; i < NUM_TRACE; i++)
			if (trace_idx == 8'(i))
				trace_val = vals[i];
	end

endmodule

`default_nettype wire

/* dv/spart_checker.sv */
`default_nettype none

module spart_checker
	import spart_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  txd,
	input  int    bit_clks,
	input  logic  exp_push,
	input  data_t exp_char,
	output int    pending,
	output logic  busy,
	output int    errors,
	output int    mismatches,
	output int    checked,
	output int    last_exp,
	output int    last_got,
	output logic  last_timing
);

	data_t expected [$];
	int    n_err;
	int    n_mis;
	int    n_chk;

	// One clock of monitoring, also takes expected characters
	task automatic step();
		@(posedge clk);
		if (exp_push)
			expected.push_back(exp_char);
		pending    <= expected.size();
		errors     <= n_err;
		mismatches <= n_mis;
		checked    <= n_chk;
	endtask

	////////////////////
	// Frame decode
	////////////////////
	task automatic decode_frame();
		data_t got;
		data_t exp;
		logic  stop;
		int    start_len;
		int    bit_no;
		got       = '0;
		stop      = 1'b0;
		start_len = 0;
		busy     <= 1'b1;
		// Clock 0 was the first one with txd low
		for (int cyc = 1; cyc <= 9 * bit_clks + bit_clks / 2; cyc++) begin
			step();
			if (start_len == 0 && txd)
				start_len = cyc;
			if (cyc % bit_clks == bit_clks / 2) begin
				bit_no = cyc / bit_clks;
				if (bit_no == 0 && txd) begin
					$display("Start bit on txd did not hold low until mid-bit");
					n_err++;
				end else if (bit_no >= 1 && bit_no <= 8) begin
					got[bit_no - 1] = txd;
				end else if (bit_no == 9) begin
					stop = txd;
				end
			end
		end
		busy <= 1'b0;
		n_chk++;
		if (!stop) begin
			$display("Stop bit on txd was low for character 8'h%02h", got);
			n_err++;
		end
		// Start bit length is visible only when data bit 0 is high
		if (got[0] && (start_len > bit_clks || start_len < bit_clks - bit_clks / 16)) begin
			last_exp    <= bit_clks;
			last_got    <= start_len;
			last_timing <= 1'b1;
			n_mis++;
			n_err++;
			step();
			step();
		end
		if (expected.size() == 0) begin
			$display("Unexpected character 8'h%02h on txd while no reply was expected", got);
			n_err++;
		end else begin
			exp = expected.pop_front();
			if (got != exp) begin
				last_exp    <= int'(exp);
				last_got    <= int'(got);
				last_timing <= 1'b0;
				n_mis++;
				n_err++;
			end
		end
	endtask

	initial begin
		pending     <= 0;
		busy        <= 1'b0;
		errors      <= 0;
		mismatches  <= 0;
		checked     <= 0;
		last_exp    <= 0;
		last_got    <= 0;
		last_timing <= 1'b0;
		n_err = 0;
		n_mis = 0;
		n_chk = 0;
		forever begin
			step();
			if (!rst && txd == 1'b0)
				decode_frame();
		end
	end

endmodule

`default_nettype wire

/* dv/tb_mini_spart.sv */
`default_nettype none

module tb_mini_spart
	import spart_pkg::*;
();

	localparam int NUM_TRACE = 6;

	typedef struct {
		string      name;
		bit         do_reset;
		logic [1:0] cfg;
		bit         load;
		data_t      cmd;
		string      echo;
		int         dump_from;
	} test_t;

	logic       clk;
	logic       rst;
	logic [1:0] br_cfg;
	logic       rxd;
	logic       txd;
	logic       wb_we;
	reg_idx_t   wb_reg;
	word_t      wb_data;
	logic       exp_push;
	data_t      exp_char;
	int         bit_clks;
	int         pending;
	int         errors;
	int         mismatches;
	int         checked;
	int         last_exp;
	int         last_got;
	logic       busy;
	logic       last_timing;

	test_t      tests [$];
	word_t      trace_model [NUM_TRACE];
	string      cur_name;
	longint     watchdog_limit;
	int         seen_mismatches;
	int         seed;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	mini_spart_top #(
		.NUM_TRACE (NUM_TRACE)
	) u_dut (
		.clk     (clk),
		.rst     (rst),
		.br_cfg  (br_cfg),
		.rxd     (rxd),
		.txd     (txd),
		.wb_we   (wb_we),
		.wb_reg  (wb_reg),
		.wb_data (wb_data)
	);

	spart_checker u_checker (
		.clk         (clk),
		.rst         (rst),
		.txd         (txd),
		.bit_clks    (bit_clks),
		.exp_push    (exp_push),
		.exp_char    (exp_char),
		.pending     (pending),
		.busy        (busy),
		.errors      (errors),
		.mismatches  (mismatches),
		.checked     (checked),
		.last_exp    (last_exp),
		.last_got    (last_got),
		.last_timing (last_timing)
	);

	// Report each mismatch the checker finds under the running test's name
	always @(posedge clk) begin
		if (mismatches != seen_mismatches) begin
			if (last_timing)
				$display("ERROR %s: start bit expected %0d clocks, actual %0d clocks",
					cur_name, last_exp, last_got);
			else
				$display("ERROR %s: expected 8'h%02h, actual 8'h%02h",
					cur_name, last_exp[7:0], last_got[7:0]);
			seen_mismatches = mismatches;
		end
	end

	// 16 ticks per bit
	function automatic int clocks_per_bit(input logic [1:0] cfg);
		case (cfg)
			2'b00:   return 16 * int'(BAUD_DIV_4800);
			2'b01:   return 16 * int'(BAUD_DIV_9600);
			2'b10:   return 16 * int'(BAUD_DIV_19200);
			default: return 16 * int'(BAUD_DIV_38400);
		endcase
	endfunction

	function automatic int reply_len(input int idx);
		return tests[idx].echo.len() + 3 * (NUM_TRACE - tests[idx].dump_from);
	endfunction

	task automatic add_test(input string name, input bit do_reset, input logic [1:0] cfg,
			input bit load, input data_t cmd, input string echo, input int dump_from);
		test_t t;
		t.name      = name;
		t.do_reset  = do_reset;
		t.cfg       = cfg;
		t.load      = load;
		t.cmd       = cmd;
		t.echo      = echo;
		t.dump_from = dump_from;
		tests.push_back(t);
	endtask

	////////////////////
	// Stimulus table
	////////////////////
	task automatic build_table();
		// name, reset, br_cfg, writeback load, command, echo, first dumped index
		add_test("baud_38400",   1, 2'b11, 0, CHAR_INC,   "1", NUM_TRACE);
		add_test("inc_again",    0, 2'b11, 0, CHAR_INC,   "2", NUM_TRACE);
		add_test("dec",          0, 2'b11, 0, CHAR_DEC,   "1", NUM_TRACE);
		add_test("dec_to_zero",  0, 2'b11, 0, CHAR_DEC,   "0", NUM_TRACE);
		add_test("dump_loaded",  0, 2'b11, 1, CHAR_ENTER, "",  0);
		add_test("enter_empty",  0, 2'b11, 0, CHAR_ENTER, "",  NUM_TRACE);
		add_test("dec_after",    0, 2'b11, 0, CHAR_DEC,   "5", NUM_TRACE);
		add_test("dump_last",    0, 2'b11, 0, CHAR_ENTER, "",  5);
		add_test("ignore_x",     0, 2'b11, 0, 8'h78,      "",  NUM_TRACE);
		add_test("ignore_9",     0, 2'b11, 0, 8'h39,      "",  NUM_TRACE);
		add_test("inc_after",    0, 2'b11, 0, CHAR_INC,   "7", NUM_TRACE);
		// Trace values were loaded above, so this reset must clear them
		add_test("baud_19200",   1, 2'b10, 0, CHAR_INC,   "1", NUM_TRACE);
		add_test("back_to_zero", 0, 2'b10, 0, CHAR_DEC,   "0", NUM_TRACE);
		add_test("dump_reset",   0, 2'b10, 0, CHAR_ENTER, "",  0);
	endtask

	// Command frame, reply frames and slack for each test, in time units
	function automatic longint run_length();
		longint total;
		int     clks;
		total = 0;
		clks  = clocks_per_bit(2'b11);
		foreach (tests[i]) begin
			if (tests[i].do_reset)
				clks = clocks_per_bit(tests[i].cfg);
			total += longint'(clks) * 10 * longint'(3 + reply_len(i)) + 100;
		end
		return total * 20;
	endfunction

	task automatic apply_reset(input logic [1:0] cfg);
		br_cfg   = cfg;
		bit_clks = clocks_per_bit(cfg);
		rst      = 1'b1;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < NUM_TRACE; i++)
			trace_model[i] = '0;
		// Divisor load needs two cycles
		repeat (4) @(posedge clk);
		#2;
	endtask

	// Registers 6 and 7 lie outside the trace block
	task automatic load_trace();
		for (int i = 0; i < 8; i++) begin
			wb_we   = 1'b1;
			wb_reg  = reg_idx_t'(i);
			wb_data = $random(seed);
			if (i < NUM_TRACE)
				trace_model[i] = wb_data;
			@(posedge clk);
			#2;
		end
		wb_we = 1'b0;
	endtask

	task automatic push_expected(input data_t c);
		exp_char = c;
		exp_push = 1'b1;
		@(posedge clk);
		#2;
		exp_push = 1'b0;
	endtask

	task automatic queue_reply(input int idx);
		for (int i = 0; i < tests[idx].echo.len(); i++)
			push_expected(data_t'(tests[idx].echo[i]));
		for (int i = tests[idx].dump_from; i < NUM_TRACE; i++) begin
			push_expected(CHAR_ZERO + data_t'(i));
			push_expected(trace_model[i][7:0]);
			push_expected(CHAR_SPACE);
		end
	endtask

	task automatic send_bit(input logic b);
		rxd = b;
		repeat (bit_clks) @(posedge clk);
		#2;
	endtask

	task automatic send_char(input data_t c);
		send_bit(1'b0);
		for (int i = 0; i < 8; i++)
			send_bit(c[i]);
		send_bit(1'b1);
	endtask

	task automatic wait_reply();
		while (pending != 0 || busy)
			@(posedge clk);
		// A stray character would start within this bit
		repeat (bit_clks) @(posedge clk);
		#2;
	endtask

	initial begin
		wait (watchdog_limit > 0);
		#(watchdog_limit);
		$display("Watchdog expired before the test sequence finished");
		$display("Test failed");
		$finish;
	end

	initial begin
		int passed;
		int failed;
		int errs_before;
		rst             = 1'b1;
		br_cfg          = 2'b11;
		rxd             = 1'b1;
		wb_we           = 1'b0;
		wb_reg          = '0;
		wb_data         = '0;
		exp_push        = 1'b0;
		exp_char        = '0;
		bit_clks        = clocks_per_bit(2'b11);
		seed            = 32'hd53453ba;
		passed          = 0;
		failed          = 0;
		cur_name        = "reset";
		build_table();
		watchdog_limit = run_length();
		foreach (tests[i]) begin
			cur_name    = tests[i].name;
			errs_before = errors;
			if (tests[i].do_reset)
				apply_reset(tests[i].cfg);
			if (tests[i].load)
				load_trace();
			queue_reply(i);
			send_char(tests[i].cmd);
			wait_reply();
			if (errors == errs_before) begin
				passed++;
				$display("PASS %s", cur_name);
			end else begin
				failed++;
				$display("FAIL %s with %0d errors", cur_name, errors - errs_before);
			end
		end
		$display("Tests: %0d passed, %0d failed, %0d characters checked, %0d errors",
			passed, failed, checked, errors);
		if (failed == 0 && errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* mini_spart.f */
common/spart_pkg.sv
common/spart_bus_if.sv
spart/spart_baud_gen.sv
spart/spart_tx.sv
spart/spart_rx.sv
spart/spart.sv
design/trace_regs.sv
design/driver.sv
design/mini_spart_top.sv
dv/spart_checker.sv
dv/tb_mini_spart.sv

/* spart/spart.sv */
`default_nettype none

module spart
	import spart_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	spart_bus_if.spart       bus,
	input  logic             rxd,
	output logic             txd
);

	logic  wr;
	logic  rd;
	logic  load_low;
	logic  load_high;
	logic  start;
	logic  read_data;
	logic  tick;
	data_t rx_data;

	////////////////////
	// Address decode
	////////////////////
	assign wr = bus.iocs & ~bus.iorw;
	assign rd = bus.iocs & bus.iorw;

	assign load_low  = wr && (bus.ioaddr == IOADDR_DB_LOW);
	assign load_high = wr && (bus.ioaddr == IOADDR_DB_HIGH);
	assign start     = wr && (bus.ioaddr == IOADDR_DATA);
	assign read_data = rd && (bus.ioaddr == IOADDR_DATA);

	// Status byte carries rda in bit 0 and tbr in bit 1
	assign bus.rdata = (bus.ioaddr == IOADDR_STATUS) ? {6'b0, bus.tbr, bus.rda} : rx_data;

	spart_baud_gen u_baud_gen (
		.clk       (clk),
		.rst       (rst),
		.load_low  (load_low),
		.load_high (load_high),
		.wdata     (bus.wdata),
		.tick      (tick)
	);

	spart_tx u_tx (
		.clk   (clk),
		.rst   (rst),
		.tick  (tick),
		.start (start),
		.wdata (bus.wdata),
		.txd   (txd),
		.tbr   (bus.tbr)
	);

	spart_rx u_rx (
		.clk       (clk),
		.rst       (rst),
		.tick      (tick),
		.rxd       (rxd),
		.read_data (read_data),
		.rx_data   (rx_data),
		.rda       (bus.rda)
	);

endmodule

`default_nettype wire

/* spart/spart_baud_gen.sv */
`default_nettype none

module spart_baud_gen
	import spart_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  load_low,
	input  logic  load_high,
	input  data_t wdata,
	output logic  tick
);

	divisor_t divisor;
	divisor_t count;
	logic     loaded;

	// Counter stays idle until the high byte completes the divisor
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			divisor <= '0;
			count   <= '0;
			loaded  <= 1'b0;
		end else begin
			if (load_low)
				divisor[7:0] <= wdata;
			if (load_high) begin
				divisor[15:8] <= wdata;
				loaded        <= 1'b1;
				count         <= {wdata, divisor[7:0]} - 16'd1;
			end else if (tick) begin
				count <= divisor - 16'd1;
			end else if (loaded) begin
				count <= count - 16'd1;
			end
		end
	end

	// One tick every divisor clocks
	assign tick = loaded && (count == '0);

endmodule

`default_nettype wire

/* spart/spart_rx.sv */
`default_nettype none

module spart_rx
	import spart_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  tick,
	input  logic  rxd,
	input  logic  read_data,
	output data_t rx_data,
	output logic  rda
);

	typedef enum logic {
		RX_IDLE,
		RX_FRAME
	} rx_state_t;

	// Count of 7 lands on the eighth tick of a bit, near mid-bit
	localparam logic [3:0] SAMPLE_TICK = 4'd7;
	localparam logic [3:0] LAST_TICK   = 4'd15;
	localparam logic [3:0] STOP_BIT    = 4'd9;

	rx_state_t  state;
	logic       rxd_meta;
	logic       rxd_sync;
	logic [3:0] tick_cnt;
	logic [3:0] bit_cnt;
	logic       sample;
	data_t      shift;

	// Two flop synchronizer, idle level is high
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	assign sample = (state == RX_FRAME) && tick && (tick_cnt == SAMPLE_TICK);

	////////////////////
	// Frame control
	////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			rda      <= 1'b0;
		end else begin
			// A new stop bit wins over a read in the same cycle
			if (sample && (bit_cnt == STOP_BIT))
				rda <= 1'b1;
			else if (read_data)
				rda <= 1'b0;

			case (state)
				RX_IDLE: begin
					if (!rxd_sync) begin
						state    <= RX_FRAME;
						tick_cnt <= '0;
						bit_cnt  <= '0;
					end
				end
				RX_FRAME: begin
					if (tick) begin
						tick_cnt <= tick_cnt + 4'd1;
						if (tick_cnt == LAST_TICK)
							bit_cnt <= bit_cnt + 4'd1;
					end
					// Glitch on the start bit or frame done
					if (sample && (((bit_cnt == '0) && rxd_sync) || (bit_cnt == STOP_BIT)))
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (sample && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8))
			shift <= {rxd_sync, shift[7:1]};
		if (sample && (bit_cnt == STOP_BIT))
			rx_data <= shift;
	end

endmodule

`default_nettype wire

/* spart/spart_tx.sv */
`default_nettype none

module spart_tx
	import spart_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  tick,
	input  logic  start,
	input  data_t wdata,
	output logic  txd,
	output logic  tbr
);

	localparam logic [3:0] LAST_TICK = 4'd15;
	localparam logic [3:0] STOP_BIT  = 4'd9;

	logic [9:0] frame;
	logic [3:0] tick_cnt;
	logic [3:0] bit_cnt;
	logic       bit_end;

	assign bit_end = !tbr && tick && (tick_cnt == LAST_TICK);

	// Stop bit, data LSB first, start bit in frame[0]
	always_ff @(posedge clk) begin
		if (start && tbr)
			frame <= {1'b1, wdata, 1'b0};
		else if (bit_end)
			frame <= {1'b1, frame[9:1]};
	end

	////////////////////
	// Bit and tick counters
	////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tbr      <= 1'b1;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else if (start && tbr) begin
			tbr      <= 1'b0;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else if (!tbr && tick) begin
			tick_cnt <= tick_cnt + 4'd1;
			if (bit_end) begin
				if (bit_cnt == STOP_BIT)
					tbr <= 1'b1;
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// Line idles high between frames
	assign txd = tbr ? 1'b1 : frame[0];

endmodule

`default_nettype wire
